/* command_processor_stimulus.txt */
// columns: frame bytes 0 to 7, response flag (1 = answered), expected response word
// for trigger arm frames byte 7 is the acquisition state driven on i_acqstate
02 00 00 00 00 00 00 00 1 0000001e
02 01 00 00 00 00 00 00 1 000000c5
03 02 11 22 33 44 00 02 1 00006969
03 05 a0 b1 c2 d3 00 03 1 0000eb98
03 07 01 02 03 04 00 04 1 0000585e
08 a0 10 02 34 55 01 00 1 00000008
08 20 30 01 ff 07 00 00 1 00000008
01 04 02 00 00 10 00 00 1 00000000
01 05 01 00 34 12 00 03 1 00000003
0a 05 01 00 00 00 00 00 1 00000000
0a 02 01 00 00 00 00 00 1 00000020
09 13 01 44 00 00 00 00 1 00000009
07 00 00 00 00 00 00 00 1 00000901
04 02 00 00 00 00 00 00 1 00000002
05 00 00 00 00 00 00 00 0 00000000
02 06 01 00 00 00 00 00 1 00000000
02 06 00 00 00 00 00 00 1 00000001

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_command_processor
FILELIST  ?= command_processor.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean
all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* command_processor.f */
host_protocol_pkg.sv
frontend_pkg.sv
frame_receiver.sv
spi_sequencer.sv
settings_regs.sv
response_sender.sv
command_processor.sv
tb_command_processor.sv

/* tb_command_processor.sv */
// command processor testbench that replays command frames from a file and checks every response
`timescale 1ns/1ps
module tb_command_processor;

   localparam int TIMEOUT = 1000;                         // cycles allowed per wait
   localparam int LINES   = 17;
   localparam int WORDS   = 10;                           // 8 bytes, flag, response

   logic                     clk50;
   logic                     pllreset2;
   logic                     i_rx_tvalid;
   logic [7:0]               i_rx_tdata;
   logic                     o_rx_tready;
   logic                     o_tx_tvalid;
   logic [31:0]              o_tx_tdata;
   logic [3:0]               o_tx_tkeep;
   logic                     o_tx_tlast;
   logic                     i_tx_tready;
   frontend_pkg::spi_out_t   o_spi;
   logic                     i_spi_tx_ready;
   logic                     i_spi_rx_dv;
   logic [7:0]               i_spi_rx;
   logic [7:0]               i_acqstate;
   logic [7:0]               i_boardin;
   logic [3:0]               i_lockinfo;
   frontend_pkg::trig_cfg_t  o_trig_cfg;
   frontend_pkg::board_ctl_t o_board_ctl;

   logic [31:0] stim [0:LINES*WORDS-1];
   integer      seed = 32'ha8b40973;
   logic [7:0]  spi_echo;
   logic [7:0]  board_out_exp;                            // board outputs written so far
   logic        fan_exp;
   logic        rolling_exp;

   command_processor UUT (.*);

   initial begin
      clk50 = 1'b0;
      forever #10 clk50 = ~clk50;
   end

   // SPI device model echoing each sent byte xor 5a
   initial begin
      i_spi_tx_ready = 1'b1;                              // never busy
      i_spi_rx_dv    = 1'b0;
      i_spi_rx       = 8'h00;
      forever begin
         @(negedge clk50);
         i_spi_rx_dv = 1'b0;
         if (o_spi.tx_dv) begin
            spi_echo = o_spi.tx_byte ^ 8'h5a;
            @(negedge clk50);
            i_spi_rx    = spi_echo;
            i_spi_rx_dv = 1'b1;                           // two cycles after the strobe
         end
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else
         abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
   endtask

   task automatic check_true(input logic ok, input string why);
      assert (ok) else abort_run(why);
   endtask

   task automatic send_byte(input logic [7:0] data);
      int wait_cnt;
      wait_cnt = 0;
      repeat ($random(seed) & 3) @(negedge clk50);       // random gap before the byte
      i_rx_tvalid = 1'b1;
      i_rx_tdata  = data;
      while (!o_rx_tready) begin                          // ready only moves on rising edges
         @(negedge clk50);
         wait_cnt++;
         check_true(wait_cnt < TIMEOUT, "timeout waiting for the input stream to take a byte");
      end
      @(negedge clk50);                                   // taken on the edge just passed
      i_rx_tvalid = 1'b0;
   endtask

   task automatic check_settings(input logic [7:0][7:0] fr, input logic [31:0] exp_word,
                                 input logic cs_low);
      logic [11:0] lo_exp;
      logic [11:0] hi_exp;
      lo_exp = 12'((int'(fr[1]) - int'(fr[2]) - 128) * 16 + 8);
      hi_exp = 12'((int'(fr[1]) + int'(fr[2]) - 128) * 16 + 8);
      case (fr[0])
         host_protocol_pkg::OP_SPI: begin
            check_true(cs_low, "the selected chip select never went low");
            check_value("o_spi.cs", 32'(o_spi.cs), 32'hff);
         end
         host_protocol_pkg::OP_TRIG_ARM: begin
            check_value("o_trig_cfg.trig_type", 32'(o_trig_cfg.trig_type), 32'(fr[1]));
            check_value("o_trig_cfg.chan_type", 32'(o_trig_cfg.chan_type), 32'(fr[2]));
            check_value("o_trig_cfg.length", 32'(o_trig_cfg.length), 32'({fr[5], fr[4]}));
            check_value("o_trig_cfg.trig_live", 32'(o_trig_cfg.trig_live),
                        32'(i_acqstate == 8'd0));
         end
         host_protocol_pkg::OP_STATUS: begin
            if (fr[1] == host_protocol_pkg::ST_FAN)
               fan_exp = fr[2][0];
            if (fr[1] == host_protocol_pkg::ST_ROLLING)
               rolling_exp = fr[2][0];
            check_value("o_trig_cfg.fan", 32'(o_trig_cfg.fan), 32'(fan_exp));
            check_value("o_trig_cfg.rolling", 32'(o_trig_cfg.rolling), 32'(rolling_exp));
         end
         host_protocol_pkg::OP_SPI_MODE: begin
            check_value("o_board_ctl.spi_mode", 32'(o_board_ctl.spi_mode), 32'(fr[1][1:0]));
            check_value("o_board_ctl.spi_reset_l", 32'(o_board_ctl.spi_reset_l), 32'h0);
         end
         host_protocol_pkg::OP_CLK_SWITCH:
            check_value("o_board_ctl.clk_switch", 32'(o_board_ctl.clk_switch), 32'(exp_word[0]));
         host_protocol_pkg::OP_TRIG_SET: begin
            check_value("o_trig_cfg.lower_thresh", 32'($unsigned(o_trig_cfg.lower_thresh)),
                        32'(lo_exp));
            check_value("o_trig_cfg.upper_thresh", 32'($unsigned(o_trig_cfg.upper_thresh)),
                        32'(hi_exp));
            check_value("o_trig_cfg.pre_offset", 32'(o_trig_cfg.pre_offset),
                        32'({fr[3][1:0], fr[4]}));
            check_value("o_trig_cfg.tot", 32'(o_trig_cfg.tot), 32'(fr[5]));
            check_value("o_trig_cfg.trig_chan", 32'(o_trig_cfg.trig_chan), 32'(fr[6][0]));
         end
         host_protocol_pkg::OP_DOWNSAMPLE: begin
            check_value("o_trig_cfg.downsample", 32'(o_trig_cfg.downsample), 32'(fr[1][4:0]));
            check_value("o_trig_cfg.high_res", 32'(o_trig_cfg.high_res), 32'(fr[2][0]));
            check_value("o_trig_cfg.ds_merging", 32'(o_trig_cfg.ds_merging), 32'(fr[3]));
         end
         host_protocol_pkg::OP_BOARDOUT: begin
            board_out_exp[fr[1][2:0]] = fr[2][0];
            check_value("o_board_ctl.board_out", 32'(o_board_ctl.board_out),
                        32'(board_out_exp));
         end
         default: ;
      endcase
   endtask

   task automatic await_response(input logic [7:0][7:0] fr, input logic [31:0] exp_word,
                                 input int stall);
      int   wait_cnt;
      logic seen;
      logic got;
      logic cs_low;
      wait_cnt    = 0;
      seen        = 1'b0;
      got         = 1'b0;
      cs_low      = 1'b0;
      i_tx_tready = 1'b0;
      i_rx_tvalid = 1'b1;                                 // host pushes ahead and must be held off
      i_rx_tdata  = 8'hee;
      while (!got) begin
         check_true(!o_rx_tready, "input stream ready while a response is pending");
         if (fr[0] == host_protocol_pkg::OP_SPI && !o_tx_tvalid) begin
            check_true(o_spi.cs == 8'hff || o_spi.cs == ~(8'h01 << fr[1][2:0]),
                       "wrong chip select pattern during the SPI transfer");
            if (o_spi.cs != 8'hff) cs_low = 1'b1;
         end
         if (o_tx_tvalid) begin
            if (!seen) check_settings(fr, exp_word, cs_low);
            seen = 1'b1;
            check_value("o_tx_tdata", o_tx_tdata, exp_word);   // steady through the stall
            check_value("o_tx_tkeep", 32'(o_tx_tkeep), 32'hf);
            check_value("o_tx_tlast", 32'(o_tx_tlast), 32'h1);
            if (stall == 0) begin
               i_tx_tready = 1'b1;
               got         = 1'b1;
            end else begin
               stall--;
            end
         end
         @(negedge clk50);
         wait_cnt++;
         check_true(wait_cnt < TIMEOUT, "timeout waiting for a response word");
      end
      i_rx_tvalid = 1'b0;
      i_tx_tready = 1'b0;
      check_value("o_tx_tvalid", 32'(o_tx_tvalid), 32'h0);
   endtask

   task automatic await_release();
      int wait_cnt;
      wait_cnt    = 0;
      i_tx_tready = 1'b1;
      while (!o_rx_tready) begin
         check_value("o_tx_tvalid", 32'(o_tx_tvalid), 32'h0);
         @(negedge clk50);
         wait_cnt++;
         check_true(wait_cnt < TIMEOUT, "timeout waiting for an unknown frame to be dropped");
      end
      check_value("o_tx_tvalid", 32'(o_tx_tvalid), 32'h0);
      i_tx_tready = 1'b0;
   endtask

   task automatic run_command(input int n);
      logic [7:0][7:0] fr;
      int              i;
      int              stall;
      for (i = 0; i < 8; i++) begin
         fr[i] = stim[n*WORDS + i][7:0];
      end
      stall = (n % 4 == 3) ? 40 : ($random(seed) & 7);   // every fourth answer held off long
      if (fr[0] == host_protocol_pkg::OP_TRIG_ARM) i_acqstate = fr[7];
      for (i = 0; i < 8; i++) begin
         send_byte(fr[i]);
      end
      if (stim[n*WORDS + 8] != 32'd0) await_response(fr, stim[n*WORDS + 9], stall);
      else await_release();
   endtask

   initial begin
      pllreset2     = 1'b1;
      i_rx_tvalid   = 1'b0;
      i_rx_tdata    = 8'h00;
      i_tx_tready   = 1'b0;
      i_acqstate    = 8'h00;
      i_boardin     = 8'hc5;                              // returned by the board-input read
      i_lockinfo    = 4'h9;
      board_out_exp = 8'h00;
      fan_exp       = 1'b0;
      rolling_exp   = 1'b0;
      $readmemh("command_processor_stimulus.txt", stim);
      repeat (8) @(negedge clk50);
      pllreset2 = 1'b0;
      check_value("o_rx_tready", 32'(o_rx_tready), 32'h0);
      check_value("o_tx_tvalid", 32'(o_tx_tvalid), 32'h0);
      check_value("o_spi.cs", 32'(o_spi.cs), 32'hff);
      check_value("o_trig_cfg.trig_live", 32'(o_trig_cfg.trig_live), 32'h0);
      for (int n = 0; n < LINES; n++) begin
         run_command(n);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

/* command_processor.sv */
// host command core: frame reception, dispatch to the SPI and settings engines, response send
`timescale 1ns/1ps
module command_processor (
   input  logic                     clk50,
   input  logic                     pllreset2,
   input  logic                     i_rx_tvalid,
   input  logic [7:0]               i_rx_tdata,
   output logic                     o_rx_tready,
   output logic                     o_tx_tvalid,
   output logic [31:0]              o_tx_tdata,
   output logic [3:0]               o_tx_tkeep,
   output logic                     o_tx_tlast,
   input  logic                     i_tx_tready,
   output frontend_pkg::spi_out_t   o_spi,
   input  logic                     i_spi_tx_ready,
   input  logic                     i_spi_rx_dv,
   input  logic [7:0]               i_spi_rx,
   input  logic [7:0]               i_acqstate,
   input  logic [7:0]               i_boardin,
   input  logic [3:0]               i_lockinfo,
   output frontend_pkg::trig_cfg_t  o_trig_cfg,
   output frontend_pkg::board_ctl_t o_board_ctl
);

   typedef enum logic [1:0] {S_IDLE, S_SPI, S_SET, S_SEND} state_t;

   state_t                        state;
   host_protocol_pkg::cmd_frame_u frame;
   host_protocol_pkg::resp_word_t spi_resp;
   host_protocol_pkg::resp_word_t set_resp;
   host_protocol_pkg::resp_word_t resp_q;                 // answer latched for the sender
   logic                          frame_valid;
   logic                          frame_done;
   logic                          spi_req;
   logic                          spi_ack;
   logic                          set_req;
   logic                          set_ack;
   logic                          load;
   logic                          snd_done;
   logic                          is_spi;
   logic                          is_set;

   always_comb begin
      is_spi = (frame.spi.opcode == host_protocol_pkg::OP_SPI);
      case (frame.spi.opcode)
         host_protocol_pkg::OP_TRIG_ARM, host_protocol_pkg::OP_STATUS,
         host_protocol_pkg::OP_SPI_MODE, host_protocol_pkg::OP_CLK_SWITCH,
         host_protocol_pkg::OP_TRIG_SET, host_protocol_pkg::OP_DOWNSAMPLE,
         host_protocol_pkg::OP_BOARDOUT: is_set = 1'b1;
         default:                        is_set = 1'b0;
      endcase
   end

   // unknown opcodes are released without an answer
   assign frame_done = (state == S_SEND && snd_done) ||
                       (state == S_IDLE && frame_valid && !is_spi && !is_set);

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state   <= S_IDLE;
         spi_req <= 1'b0;
         set_req <= 1'b0;
         load    <= 1'b0;
      end else begin
         load <= 1'b0;
         case (state)
            S_IDLE: begin
               if (frame_valid && is_spi) begin
                  spi_req <= 1'b1;
                  state   <= S_SPI;
               end else if (frame_valid && is_set) begin
                  set_req <= 1'b1;
                  state   <= S_SET;
               end
            end
            S_SPI: begin
               if (spi_ack) begin
                  spi_req <= 1'b0;
                  load    <= 1'b1;
                  state   <= S_SEND;
               end
            end
            S_SET: begin
               if (set_ack) begin
                  set_req <= 1'b0;
                  load    <= 1'b1;
                  state   <= S_SEND;
               end
            end
            S_SEND: if (snd_done) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk50) begin
      if (state == S_SPI && spi_ack) resp_q <= spi_resp;
      else if (state == S_SET && set_ack) resp_q <= set_resp;
   end

   frame_receiver u_rx (
      .clk50(clk50), .pllreset2(pllreset2), .i_tvalid(i_rx_tvalid), .i_tdata(i_rx_tdata),
      .i_frame_done(frame_done), .o_tready(o_rx_tready), .o_frame_valid(frame_valid),
      .o_frame(frame)
   );

   spi_sequencer u_spi (
      .clk50(clk50), .pllreset2(pllreset2), .i_req(spi_req), .i_frame(frame),
      .i_tx_ready(i_spi_tx_ready), .i_rx_dv(i_spi_rx_dv), .i_rx(i_spi_rx),
      .o_ack(spi_ack), .o_resp(spi_resp), .o_spi(o_spi)
   );

   settings_regs u_set (
      .clk50(clk50), .pllreset2(pllreset2), .i_req(set_req), .i_frame_done(frame_done),
      .i_frame(frame), .i_acqstate(i_acqstate), .i_boardin(i_boardin), .i_lockinfo(i_lockinfo),
      .o_ack(set_ack), .o_resp(set_resp), .o_trig_cfg(o_trig_cfg), .o_board_ctl(o_board_ctl)
   );

   response_sender u_tx (
      .clk50(clk50), .pllreset2(pllreset2), .i_load(load), .i_word(resp_q),
      .i_tready(i_tx_tready), .o_tvalid(o_tx_tvalid), .o_tdata(o_tx_tdata),
      .o_tkeep(o_tx_tkeep), .o_tlast(o_tx_tlast), .o_done(snd_done)
   );

endmodule

/* response_sender.sv */
// response sender: puts one 32-bit response word on the outgoing stream
`timescale 1ns/1ps
module response_sender (
   input  logic                          clk50,
   input  logic                          pllreset2,
   input  logic                          i_load,
   input  host_protocol_pkg::resp_word_t i_word,
   input  logic                          i_tready,
   output logic                          o_tvalid,
   output logic [31:0]                   o_tdata,
   output logic [3:0]                    o_tkeep,
   output logic                          o_tlast,
   output logic                          o_done
);

   assign o_done  = o_tvalid && i_tready;                 // beat taken this cycle
   assign o_tkeep = 4'b1111;                              // always a full word
   assign o_tlast = 1'b1;                                 // single beat per response

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_tvalid <= 1'b0;
      end else if (i_load) begin
         o_tvalid <= 1'b1;
      end else if (o_done) begin
         o_tvalid <= 1'b0;
      end
   end

   // word stays put while the host stalls
   always_ff @(posedge clk50) begin
      if (i_load) o_tdata <= i_word;
   end

endmodule

/* settings_regs.sv */
// settings engine that holds the configuration registers and answers the non-SPI commands
`timescale 1ns/1ps
module settings_regs (
   input  logic                          clk50,
   input  logic                          pllreset2,
   input  logic                          i_req,
   input  logic                          i_frame_done,
   input  host_protocol_pkg::cmd_frame_u i_frame,
   input  logic [7:0]                    i_acqstate,
   input  logic [7:0]                    i_boardin,
   input  logic [3:0]                    i_lockinfo,
   output logic                          o_ack,
   output host_protocol_pkg::resp_word_t o_resp,
   output frontend_pkg::trig_cfg_t       o_trig_cfg,
   output frontend_pkg::board_ctl_t      o_board_ctl
);

   host_protocol_pkg::resp_word_t resp_d;
   logic                          take;                   // new request for one cycle
   logic [11:0]                   thr_diff;
   logic [11:0]                   thr_sum;

   assign take     = i_req && !o_ack;
   assign thr_diff = 12'(i_frame.bytes[1]) - 12'(i_frame.bytes[2]) - frontend_pkg::THRESH_OFFSET;
   assign thr_sum  = 12'(i_frame.bytes[1]) + 12'(i_frame.bytes[2]) - frontend_pkg::THRESH_OFFSET;

   always_comb begin
      resp_d = '0;
      case (i_frame.bytes[0])
         host_protocol_pkg::OP_TRIG_ARM: resp_d[7:0] = i_acqstate;
         host_protocol_pkg::OP_STATUS: begin
            case (i_frame.bytes[1])
               host_protocol_pkg::ST_VERSION: resp_d = host_protocol_pkg::FIRMWARE_VERSION;
               host_protocol_pkg::ST_BOARDIN: resp_d[7:0] = i_boardin;
               host_protocol_pkg::ST_FAN:     resp_d[0] = o_trig_cfg.fan;     // value before write
               host_protocol_pkg::ST_ROLLING: resp_d[0] = o_trig_cfg.rolling;
               default:                       resp_d = '0;
            endcase
         end
         host_protocol_pkg::OP_SPI_MODE: resp_d[7:0] = i_frame.bytes[1];
         host_protocol_pkg::OP_CLK_SWITCH: begin
            resp_d[11:8] = i_lockinfo;
            resp_d[0]    = ~o_board_ctl.clk_switch;       // switch value after toggle
         end
         host_protocol_pkg::OP_TRIG_SET:   resp_d = host_protocol_pkg::RESP_TRIG_SET;
         host_protocol_pkg::OP_DOWNSAMPLE: resp_d = host_protocol_pkg::RESP_DOWNSAMPLE;
         host_protocol_pkg::OP_BOARDOUT:   resp_d[7:0] = o_board_ctl.board_out;
         default:                          resp_d = '0;
      endcase
   end

   always_ff @(posedge clk50) begin
      if (take) o_resp <= resp_d;
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_ack       <= 1'b0;
         o_trig_cfg  <= '0;
         o_board_ctl <= '{board_out: 8'h00, clk_switch: 1'b0, spi_mode: 2'd0, spi_reset_l: 1'b1};
      end else begin
         if (take) o_ack <= 1'b1;
         else if (!i_req) o_ack <= 1'b0;
         if (i_frame_done) o_trig_cfg.trig_live <= 1'b0; // live only for the arming command
         if (take) begin
            case (i_frame.bytes[0])
               host_protocol_pkg::OP_TRIG_ARM: begin
                  o_trig_cfg.trig_type <= i_frame.bytes[1];
                  o_trig_cfg.chan_type <= i_frame.bytes[2];
                  o_trig_cfg.length    <= {i_frame.bytes[5], i_frame.bytes[4]};
                  if (i_acqstate == 8'd0) o_trig_cfg.trig_live <= 1'b1; // arm only when idle
               end
               host_protocol_pkg::OP_STATUS: begin
                  if (i_frame.bytes[1] == host_protocol_pkg::ST_FAN)
                     o_trig_cfg.fan <= i_frame.bytes[2][0];
                  if (i_frame.bytes[1] == host_protocol_pkg::ST_ROLLING)
                     o_trig_cfg.rolling <= i_frame.bytes[2][0];
               end
               host_protocol_pkg::OP_SPI_MODE: begin
                  o_board_ctl.spi_mode    <= i_frame.bytes[1][1:0];
                  o_board_ctl.spi_reset_l <= 1'b0;
               end
               host_protocol_pkg::OP_CLK_SWITCH: o_board_ctl.clk_switch <= ~o_board_ctl.clk_switch;
               host_protocol_pkg::OP_TRIG_SET: begin
                  o_trig_cfg.lower_thresh <= (thr_diff << 4) + 12'd8;
                  o_trig_cfg.upper_thresh <= (thr_sum << 4) + 12'd8;
                  o_trig_cfg.pre_offset   <= {i_frame.bytes[3][1:0], i_frame.bytes[4]};
                  o_trig_cfg.tot          <= i_frame.bytes[5];
                  o_trig_cfg.trig_chan    <= i_frame.bytes[6][0];
               end
               host_protocol_pkg::OP_DOWNSAMPLE: begin
                  o_trig_cfg.downsample <= i_frame.bytes[1][4:0];
                  o_trig_cfg.high_res   <= i_frame.bytes[2][0];
                  o_trig_cfg.ds_merging <= i_frame.bytes[3];
               end
               host_protocol_pkg::OP_BOARDOUT:
                  o_board_ctl.board_out[i_frame.bytes[1][2:0]] <= i_frame.bytes[2][0];
               default: ;
            endcase
         end
      end
   end

endmodule

/* spi_sequencer.sv */
// SPI command engine: one chip-select framed transfer of 2 to 4 bytes with readback
`timescale 1ns/1ps
module spi_sequencer (
   input  logic                          clk50,
   input  logic                          pllreset2,
   input  logic                          i_req,
   input  host_protocol_pkg::cmd_frame_u i_frame,
   input  logic                          i_tx_ready,
   input  logic                          i_rx_dv,
   input  logic [7:0]                    i_rx,
   output logic                          o_ack,
   output host_protocol_pkg::resp_word_t o_resp,
   output frontend_pkg::spi_out_t        o_spi
);

   typedef enum logic [2:0] {S_IDLE, S_SETUP, S_SEND, S_RX, S_HOLD} state_t;

   state_t                state;
   frontend_pkg::cs_cnt_t cnt;
   logic [1:0]            idx;                            // tx byte being sent
   logic [1:0]            next_idx;
   logic [2:0]            n_sent;
   logic                  last;
   logic                  tx_dv;
   logic [7:0]            tx_byte;
   logic [7:0]            cs;

   // 2 bytes sends tx[0] and tx[2], tx[3] only for 4 bytes
   assign last     = (idx == 2'd3) || (idx == 2'd2 && i_frame.spi.byte_count != 8'd4);
   assign next_idx = (idx == 2'd0 && i_frame.spi.byte_count == 8'd2) ? 2'd2 : idx + 2'd1;
   assign o_spi    = '{tx_byte: tx_byte, tx_dv: tx_dv, cs: cs};

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state  <= S_IDLE;
         o_ack  <= 1'b0;
         tx_dv  <= 1'b0;
         cs     <= '1;
         cnt    <= '0;
         idx    <= '0;
         n_sent <= '0;
      end else begin
         tx_dv <= 1'b0;
         case (state)
            S_IDLE: begin
               if (i_req && !o_ack) begin
                  cs[i_frame.spi.cs_idx[2:0]] <= 1'b0;
                  cnt    <= '0;
                  idx    <= '0;
                  n_sent <= '0;
                  state  <= S_SETUP;
               end else if (!i_req) begin
                  o_ack <= 1'b0;                          // req dropped, close handshake
               end
            end
            S_SETUP: begin
               if (cnt == frontend_pkg::CS_SETUP_CYCLES) begin
                  cnt   <= '0;
                  state <= S_SEND;
               end else begin
                  cnt <= cnt + 6'd1;
               end
            end
            S_SEND: begin
               if (i_tx_ready) begin
                  tx_dv  <= 1'b1;
                  n_sent <= n_sent + 3'd1;
                  state  <= S_RX;
               end
            end
            S_RX: begin
               if (i_rx_dv) begin
                  idx   <= next_idx;
                  state <= last ? S_HOLD : S_SEND;
               end
            end
            S_HOLD: begin
               if (cnt == frontend_pkg::CS_HOLD_CYCLES) begin
                  cnt   <= '0;
                  cs    <= '1;
                  o_ack <= 1'b1;
                  state <= S_IDLE;
               end else begin
                  cnt <= cnt + 6'd1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk50) begin
      if (state == S_SEND && i_tx_ready) tx_byte <= i_frame.spi.tx[idx];
      if (state == S_IDLE && i_req && !o_ack) o_resp <= '0;
      if (state == S_RX && i_rx_dv) begin
         if (n_sent == 3'd2) o_resp[15:8] <= i_rx;        // read during second byte
         if (last) o_resp[7:0] <= i_rx;
      end
   end

endmodule

/* frame_receiver.sv */
// command frame receiver: gathers eight stream bytes into one frame and holds it until answered
`timescale 1ns/1ps
module frame_receiver (
   input  logic                          clk50,
   input  logic                          pllreset2,
   input  logic                          i_tvalid,
   input  logic [7:0]                    i_tdata,
   input  logic                          i_frame_done,
   output logic                          o_tready,
   output logic                          o_frame_valid,
   output host_protocol_pkg::cmd_frame_u o_frame
);

   logic [2:0] byte_cnt;                                  // next byte slot
   logic       busy;                                      // frame waits for its answer
   logic       accept;

   assign accept = i_tvalid && o_tready;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         byte_cnt      <= '0;
         busy          <= 1'b0;
         o_tready      <= 1'b0;
         o_frame_valid <= 1'b0;
      end else begin
         o_frame_valid <= 1'b0;
         if (busy) begin
            if (i_frame_done) begin
               busy     <= 1'b0;
               o_tready <= 1'b1;
            end
         end else if (accept && byte_cnt == 3'(host_protocol_pkg::FRAME_BYTES - 1)) begin
            byte_cnt      <= '0;
            busy          <= 1'b1;
            o_tready      <= 1'b0;                        // stall host until answered
            o_frame_valid <= 1'b1;
         end else begin
            o_tready <= 1'b1;
            if (accept) byte_cnt <= byte_cnt + 3'd1;
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (accept) o_frame.bytes[byte_cnt] <= i_tdata;
   end

endmodule

/* frontend_pkg.sv */
// analog front end: trigger, board control and SPI bus types with their timing constants
package frontend_pkg;

   typedef logic [5:0] cs_cnt_t;                          // chip select wait counter

   localparam cs_cnt_t CS_SETUP_CYCLES = 6'd10;           // after chip select falls
   localparam cs_cnt_t CS_HOLD_CYCLES  = 6'd35;           // after the last byte
   localparam logic [11:0] THRESH_OFFSET = 12'd128;       // mid-scale of the threshold bytes

   typedef struct packed {
      logic signed [11:0] lower_thresh;
      logic signed [11:0] upper_thresh;
      logic [9:0]         pre_offset;                     // samples kept before the trigger
      logic [7:0]         tot;                            // time over threshold
      logic               trig_chan;
      logic [7:0]         trig_type;
      logic [7:0]         chan_type;
      logic [15:0]        length;                         // capture length to take
      logic               trig_live;
      logic               rolling;
      logic               fan;
      logic [4:0]         downsample;
      logic               high_res;
      logic [7:0]         ds_merging;
   } trig_cfg_t;

   typedef struct packed {
      logic [7:0] board_out;                              // relay and spare outputs
      logic       clk_switch;                             // external vs internal clock
      logic [1:0] spi_mode;
      logic       spi_reset_l;
   } board_ctl_t;

   typedef struct packed {
      logic [7:0] tx_byte;
      logic       tx_dv;                                  // one-cycle send strobe
      logic [7:0] cs;                                     // active low chip selects
   } spi_out_t;

endpackage

/* host_protocol_pkg.sv */
// host USB protocol: opcodes, status sub-codes, responses and command frame layout
package host_protocol_pkg;

   localparam int FRAME_BYTES = 8;                        // bytes per command frame
   localparam logic [31:0] FIRMWARE_VERSION = 32'd30;

   // opcodes in frame byte 0
   localparam logic [7:0] OP_TRIG_ARM    = 8'd1;
   localparam logic [7:0] OP_STATUS      = 8'd2;
   localparam logic [7:0] OP_SPI         = 8'd3;
   localparam logic [7:0] OP_SPI_MODE    = 8'd4;
   localparam logic [7:0] OP_CLK_SWITCH  = 8'd7;
   localparam logic [7:0] OP_TRIG_SET    = 8'd8;
   localparam logic [7:0] OP_DOWNSAMPLE  = 8'd9;
   localparam logic [7:0] OP_BOARDOUT    = 8'd10;

   // status sub-codes in frame byte 1
   localparam logic [7:0] ST_VERSION = 8'd0;
   localparam logic [7:0] ST_BOARDIN = 8'd1;
   localparam logic [7:0] ST_FAN     = 8'd6;
   localparam logic [7:0] ST_ROLLING = 8'd8;

   // fixed acknowledge words
   localparam logic [31:0] RESP_TRIG_SET   = 32'd8;
   localparam logic [31:0] RESP_DOWNSAMPLE = 32'd9;

   typedef logic [31:0] resp_word_t;

   // SPI command layout, byte 7 at the top
   typedef struct packed {
      logic [7:0]      byte_count;                        // byte 7, 2 to 4 bytes sent
      logic [7:0]      spare;                             // byte 6
      logic [3:0][7:0] tx;                                // bytes 5..2, tx[0] goes first
      logic [7:0]      cs_idx;                            // byte 1, chip to select
      logic [7:0]      opcode;                            // byte 0
   } spi_frame_t;

   // one frame seen as plain bytes or as an SPI command
   typedef union packed {
      logic [FRAME_BYTES-1:0][7:0] bytes;                 // bytes[0] arrives first
      spi_frame_t                  spi;
   } cmd_frame_u;

endpackage
